// File: include/bridge_defs.svh
/*
 * Bus widths, line geometry and AXI ids of the cache bridge.
 * Included by both packages, the burst engines and the testbench.
 */
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// address and data beat widths
`define ADDR_W      32
`define DATA_W      32

// words per cache line, one AXI beat each
`define LINE_WORDS  4

// AXI id width and the ids used by each engine
`define AXI_ID_W    4
`define REFILL_ID   1
`define WB_ID       1

`endif

// File: logic/axi_pkg.sv
/*
 * AXI channel payload types for the single master port.
 * Valid and ready travel beside these structs as plain logic.
 */
`include "bridge_defs.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef logic [`AXI_ID_W-1:0] axi_id_t;
    // 4-bit burst length, enough for one line
    typedef logic [3:0]           axi_len_t;

    // shared by AR and AW
    typedef struct packed {
        axi_id_t            id;
        logic [`ADDR_W-1:0] addr;
        axi_len_t           len;
        logic [2:0]         size;
        axi_burst_e         burst;
    } axi_addr_t;

    typedef struct packed {
        axi_id_t            id;
        logic [`DATA_W-1:0] data;
        logic [1:0]         resp;
        logic               last;
    } axi_r_t;

    typedef struct packed {
        logic [`DATA_W-1:0]   data;
        logic [`DATA_W/8-1:0] strb;
        logic                 last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t    id;
        logic [1:0] resp;
    } axi_b_t;

endpackage

// File: logic/cache_pkg.sv
/*
 * Cache-side types: the request opcode, the line and the request struct.
 * The cache holds a cache_req_t stable while its req is high.
 */
`include "bridge_defs.svh"

package cache_pkg;

    typedef enum logic {
        OP_REFILL    = 1'b0,
        OP_WRITEBACK = 1'b1
    } cache_op_e;

    // word 0 sits at the line address
    typedef logic [`LINE_WORDS-1:0][`DATA_W-1:0] cache_line_t;

    typedef struct packed {
        cache_op_e          op;
        logic [`ADDR_W-1:0] line_addr;
        // only meaningful for a writeback
        cache_line_t        wline;
    } cache_req_t;

endpackage

// File: logic/cache_req_port.sv
/*
 * Four-phase req/ack port toward the data cache.
 * Latches one request, fires the matching burst engine and acks
 * once that engine is done. Ack stays up until req falls.
 */
`include "bridge_defs.svh"

module cache_req_port (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  cache_pkg::cache_req_t  cache_req,
    output logic                   ack,
    output logic                   start_refill,
    output logic                   start_wb,
    output logic [`ADDR_W-1:0]     line_addr,
    output cache_pkg::cache_line_t wb_line,
    input  logic                   refill_done,
    input  logic                   wb_done
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACKED
    } port_state_e;

    port_state_e state;
    port_state_e state_next;
    cache_op_e   op_q;
    logic        take;
    logic        op_done;

    // new request seen while idle
    assign take    = (state == ST_IDLE) && req;
    assign op_done = (op_q == OP_REFILL) ? refill_done : wb_done;
    assign ack     = (state == ST_ACKED);

    always_comb begin
        state_next = state;
        unique case (state)
            ST_IDLE: begin
                if (req) begin
                    state_next = ST_BUSY;
                end
            end
            ST_BUSY: begin
                if (op_done) begin
                    state_next = ST_ACKED;
                end
            end
            // hold ack until the cache drops req
            ST_ACKED: begin
                if (!req) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            op_q         <= OP_REFILL;
            start_refill <= 1'b0;
            start_wb     <= 1'b0;
        end else begin
            state        <= state_next;
            start_refill <= take && (cache_req.op == OP_REFILL);
            start_wb     <= take && (cache_req.op == OP_WRITEBACK);
            if (take) begin
                op_q <= cache_req.op;
            end
        end
    end

    // request payload, captured on the accepting edge
    always_ff @(posedge clk) begin
        if (take) begin
            line_addr <= cache_req.line_addr;
            wb_line   <= cache_req.wline;
        end
    end

endmodule

// File: logic/line_refill_engine.sv
/*
 * Read-burst engine for a line refill.
 * One INCR burst of LINE_WORDS beats, each stored at its beat index.
 */
`include "bridge_defs.svh"

module line_refill_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`ADDR_W-1:0]     line_addr,
    output axi_pkg::axi_addr_t     ar,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    input  axi_pkg::axi_r_t        r,
    input  logic                   r_valid,
    output logic                   r_ready,
    output cache_pkg::cache_line_t rline,
    output logic                   done
);
    import axi_pkg::*;

    localparam int CNT_W = (`LINE_WORDS > 1) ? $clog2(`LINE_WORDS) : 1;

    typedef enum logic [1:0] {IDLE, ADDR, DATA, FINISH} rd_state_e;

    rd_state_e  state;
    rd_state_e  state_next;
    logic [CNT_W-1:0] beat_cnt;
    logic       beat;

    assign beat     = (state == DATA) && r_valid;
    assign ar_valid = (state == ADDR);
    assign r_ready  = (state == DATA);
    assign done     = (state == FINISH);

    // fixed burst shape, 4-byte beats
    always_comb begin
        ar.id    = axi_id_t'(`REFILL_ID);
        ar.addr  = line_addr;
        ar.len   = axi_len_t'(`LINE_WORDS - 1);
        ar.size  = 3'd2;
        ar.burst = BURST_INCR;
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE:    if (start) state_next = ADDR;
            ADDR:    if (ar_ready) state_next = DATA;
            DATA:    if (beat && r.last) state_next = FINISH;
            FINISH:  state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == ADDR) begin
                beat_cnt <= '0;
            end else if (beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat) begin
            rline[beat_cnt] <= r.data;
        end
    end

endmodule

// File: logic/line_writeback_engine.sv
/*
 * Write-burst engine for a line writeback.
 * Sends AW, then LINE_WORDS W beats with full strobes, then waits
 * for the B response before signalling done.
 */
`include "bridge_defs.svh"

module line_writeback_engine (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`ADDR_W-1:0]     line_addr,
    input  cache_pkg::cache_line_t wb_line,
    output axi_pkg::axi_addr_t     aw,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output axi_pkg::axi_w_t        w,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  axi_pkg::axi_b_t        b,
    input  logic                   b_valid,
    output logic                   b_ready,
    output logic                   done
);
    import axi_pkg::*;

    localparam int CNT_W = (`LINE_WORDS > 1) ? $clog2(`LINE_WORDS) : 1;

    typedef enum logic [2:0] {IDLE, ADDR, DATA, RESP, FINISH} wb_state_e;

    wb_state_e  state;
    wb_state_e  state_next;
    logic [CNT_W-1:0] beat_cnt;
    logic       w_fire;

    assign w_fire   = w_valid && w_ready;
    assign aw_valid = (state == ADDR);
    assign w_valid  = (state == DATA);
    assign b_ready  = (state == RESP);
    assign done     = (state == FINISH);

    always_comb begin
        aw.id    = axi_id_t'(`WB_ID);
        aw.addr  = line_addr;
        aw.len   = axi_len_t'(`LINE_WORDS - 1);
        aw.size  = 3'd2;
        aw.burst = BURST_INCR;
    end

    // beat data follows the counter, so it holds under back-pressure
    always_comb begin
        w.data = wb_line[beat_cnt];
        w.strb = '1;
        w.last = (beat_cnt == CNT_W'(`LINE_WORDS - 1));
    end

    always_comb begin
        state_next = state;
        unique case (state)
            IDLE:    if (start) state_next = ADDR;
            ADDR:    if (aw_ready) state_next = DATA;
            DATA:    if (w_fire && w.last) state_next = RESP;
            // response code is not inspected
            RESP:    if (b_valid) state_next = FINISH;
            FINISH:  state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == ADDR) begin
                beat_cnt <= '0;
            end else if (w_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

// File: logic/cache_axi_bridge.sv
/*
 * Top level of the data-cache AXI bridge.
 * Connects the request port to the refill and writeback engines,
 * which drive the AXI master channels directly.
 */
`include "bridge_defs.svh"

module cache_axi_bridge (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  cache_pkg::cache_req_t  cache_req,
    output logic                   ack,
    output cache_pkg::cache_line_t rline,
    output axi_pkg::axi_addr_t     ar,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    input  axi_pkg::axi_r_t        r,
    input  logic                   r_valid,
    output logic                   r_ready,
    output axi_pkg::axi_addr_t     aw,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output axi_pkg::axi_w_t        w,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  axi_pkg::axi_b_t        b,
    input  logic                   b_valid,
    output logic                   b_ready
);
    import cache_pkg::*;

    logic               start_refill;
    logic               start_wb;
    logic               refill_done;
    logic               wb_done;
    logic [`ADDR_W-1:0] line_addr;
    cache_line_t        wb_line;

    cache_req_port cache_req_port_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .cache_req    (cache_req),
        .ack          (ack),
        .start_refill (start_refill),
        .start_wb     (start_wb),
        .line_addr    (line_addr),
        .wb_line      (wb_line),
        .refill_done  (refill_done),
        .wb_done      (wb_done)
    );

    line_refill_engine line_refill_engine_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start_refill),
        .line_addr (line_addr),
        .ar        (ar),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .r         (r),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .rline     (rline),
        .done      (refill_done)
    );

    line_writeback_engine line_writeback_engine_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start_wb),
        .line_addr (line_addr),
        .wb_line   (wb_line),
        .aw        (aw),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .w         (w),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .b         (b),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .done      (wb_done)
    );

endmodule

// File: sim/tb_axi_mem.sv
/*
 * AXI slave memory model for the bridge testbench.
 * Serves one read burst and one write burst at a time. Ready and valid
 * delays come from a Galois LFSR, one step for each bit taken.
 */
`include "bridge_defs.svh"

module tb_axi_mem #(
    parameter int          DEPTH = 256,
    parameter logic [31:0] FILL  = 32'h0,
    parameter logic [31:0] SEED  = 32'h1
) (
    input  logic               clk,
    input  logic               rst_n,
    input  axi_pkg::axi_addr_t ar,
    input  logic               ar_valid,
    output logic               ar_ready,
    output axi_pkg::axi_r_t    r,
    output logic               r_valid,
    input  logic               r_ready,
    input  axi_pkg::axi_addr_t aw,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  axi_pkg::axi_w_t    w,
    input  logic               w_valid,
    output logic               w_ready,
    output axi_pkg::axi_b_t    b,
    output logic               b_valid,
    input  logic               b_ready
);
    timeunit 1ns;
    timeprecision 1ps;
    import axi_pkg::*;

    localparam int IDX_W = $clog2(DEPTH);

    logic [`DATA_W-1:0] mem [0:DEPTH-1];
    logic [31:0]        lfsr;
    logic               rd_busy;
    logic [IDX_W-1:0]   rd_idx;
    int                 rd_cnt;
    axi_id_t            rd_id;
    axi_len_t           rd_len;
    logic [IDX_W-1:0]   wr_idx;
    logic [1:0]         wr_phase;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // word i holds i xor the fill constant
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = FILL ^ 32'(i);
        end
    end

    always @(posedge clk) begin : slave_fsm
        logic [31:0] s;
        logic [4:0]  rb;
        s = lfsr;
        for (int k = 0; k < 5; k++) begin
            rb[k] = s[0];
            s = lfsr_step(s);
        end
        if (!rst_n) begin
            lfsr     <= SEED;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            rd_busy  <= 1'b0;
            wr_phase <= 2'd0;
            r        <= '0;
            b        <= '0;
        end else begin
            lfsr <= s;
            // read side
            if (!rd_busy) begin
                if (ar_valid && ar_ready) begin
                    rd_busy  <= 1'b1;
                    rd_idx   <= ar.addr[IDX_W+1:2];
                    rd_id    <= ar.id;
                    rd_len   <= ar.len;
                    rd_cnt   <= 0;
                    ar_ready <= 1'b0;
                end else begin
                    ar_ready <= rb[0];
                end
            end else if (r_valid && r_ready) begin
                r_valid <= 1'b0;
                rd_idx  <= rd_idx + IDX_W'(1);
                rd_cnt  <= rd_cnt + 1;
                if (r.last) begin
                    rd_busy <= 1'b0;
                end
            end else if (!r_valid && rb[1]) begin
                r_valid <= 1'b1;
                // burst length follows the AR len field
                r       <= '{id: rd_id, data: mem[rd_idx], resp: 2'b00,
                             last: (rd_cnt == int'(rd_len))};
            end
            // write side: address, data beats, then response
            case (wr_phase)
                2'd0: begin
                    if (aw_valid && aw_ready) begin
                        wr_idx   <= aw.addr[IDX_W+1:2];
                        b        <= '{id: aw.id, resp: 2'b00};
                        aw_ready <= 1'b0;
                        wr_phase <= 2'd1;
                    end else begin
                        aw_ready <= rb[2];
                    end
                end
                2'd1: begin
                    if (w_valid && w_ready) begin
                        mem[wr_idx] <= w.data;
                        wr_idx      <= wr_idx + IDX_W'(1);
                        w_ready     <= 1'b0;
                        if (w.last) begin
                            wr_phase <= 2'd2;
                        end
                    end else begin
                        w_ready <= rb[3];
                    end
                end
                default: begin
                    if (b_valid && b_ready) begin
                        b_valid  <= 1'b0;
                        wr_phase <= 2'd0;
                    end else if (rb[4]) begin
                        b_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: sim/tb_top.sv
/*
 * Testbench for the cache AXI bridge.
 * Issues refill and writeback requests over the four-phase port against
 * an AXI memory model. Concurrent assertions do all of the checking.
 */
`include "bridge_defs.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import axi_pkg::*;
    import cache_pkg::*;

    localparam int          MEM_DEPTH = 256;
    localparam logic [31:0] MEM_FILL  = 32'ha5c3_1e07;
    localparam logic [31:0] SEED      = 32'h5fa20ead;
    localparam int          TIMEOUT   = 400;

    logic               clk;
    logic               rst_n;
    logic               req;
    cache_req_t         cache_req;
    logic               ack;
    cache_line_t        rline;
    axi_addr_t          ar;
    logic               ar_valid;
    logic               ar_ready;
    axi_r_t             r;
    logic               r_valid;
    logic               r_ready;
    axi_addr_t          aw;
    logic               aw_valid;
    logic               aw_ready;
    axi_w_t             w;
    logic               w_valid;
    logic               w_ready;
    axi_b_t             b;
    logic               b_valid;
    logic               b_ready;
    cache_line_t        exp_line;
    logic [`DATA_W-1:0] shadow [0:MEM_DEPTH-1];
    logic [31:0]        lfsr;
    int                 r_beats;
    int                 w_beats;
    logic               aw_seen;

    always #20 clk = ~clk;

    cache_axi_bridge cache_axi_bridge_i (
        .clk (clk), .rst_n (rst_n), .req (req), .cache_req (cache_req),
        .ack (ack), .rline (rline),
        .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
        .r (r), .r_valid (r_valid), .r_ready (r_ready),
        .aw (aw), .aw_valid (aw_valid), .aw_ready (aw_ready),
        .w (w), .w_valid (w_valid), .w_ready (w_ready),
        .b (b), .b_valid (b_valid), .b_ready (b_ready)
    );

    tb_axi_mem #(.DEPTH (MEM_DEPTH), .FILL (MEM_FILL), .SEED (SEED)) axi_mem_i (
        .clk (clk), .rst_n (rst_n),
        .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
        .r (r), .r_valid (r_valid), .r_ready (r_ready),
        .aw (aw), .aw_valid (aw_valid), .aw_ready (aw_ready),
        .w (w), .w_valid (w_valid), .w_ready (w_ready),
        .b (b), .b_valid (b_valid), .b_ready (b_ready)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic value_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("Timeout: %s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped on timeout");
    endtask

    // one lfsr step per data bit
    task automatic make_line(output cache_line_t line);
        for (int k = 0; k < `LINE_WORDS; k++) begin
            for (int i = 0; i < `DATA_W; i++) begin
                line[k] = {line[k][`DATA_W-2:0], lfsr[0]};
                lfsr = lfsr_step(lfsr);
            end
        end
    endtask

    task automatic run_request(input cache_op_e op, input logic [`ADDR_W-1:0] addr,
                               input cache_line_t line);
        int          cycles;
        int          base;
        cache_line_t expect_v;
        base = int'(addr >> 2);
        for (int k = 0; k < `LINE_WORDS; k++) begin
            expect_v[k] = (op == OP_REFILL) ? shadow[base+k] : line[k];
        end
        @(posedge clk);
        exp_line  <= expect_v;
        cache_req <= '{op: op, line_addr: addr, wline: line};
        req       <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack && cycles < TIMEOUT);
        if (!ack) begin
            abort_run("ack did not rise while req was high");
        end
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack && cycles < TIMEOUT);
        if (ack) begin
            abort_run("ack did not fall after req was released");
        end
        if (op == OP_WRITEBACK) begin
            for (int k = 0; k < `LINE_WORDS; k++) begin
                shadow[base+k] = line[k];
            end
        end
    endtask

    // beat positions within the current bursts
    always @(posedge clk) begin
        if (!rst_n) begin
            r_beats <= 0;
            w_beats <= 0;
            aw_seen <= 1'b0;
        end else begin
            if (r_valid && r_ready) begin
                r_beats <= r.last ? 0 : r_beats + 1;
            end
            if (aw_valid && aw_ready) begin
                aw_seen <= 1'b1;
            end
            if (w_valid && w_ready) begin
                w_beats <= w.last ? 0 : w_beats + 1;
                if (w.last) begin
                    aw_seen <= 1'b0;
                end
            end
        end
    end

    reset_idle: assert property (@(posedge clk)
        !rst_n |=> !(ack || ar_valid || aw_valid || w_valid || r_ready || b_ready))
        else value_error("control outputs not low after reset");

    refill_data: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && cache_req.op == OP_REFILL) |-> rline == exp_line)
        else value_error("refilled line differs from expected memory words");

    ar_fields: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid |-> (ar.len == axi_len_t'(`LINE_WORDS - 1) && ar.size == 3'd2
                      && ar.burst == BURST_INCR && ar.id == axi_id_t'(`REFILL_ID)
                      && ar.addr == cache_req.line_addr))
        else value_error("wrong AR burst fields");

    aw_fields: assert property (@(posedge clk) disable iff (!rst_n)
        aw_valid |-> (aw.len == axi_len_t'(`LINE_WORDS - 1) && aw.size == 3'd2
                      && aw.burst == BURST_INCR && aw.id == axi_id_t'(`WB_ID)
                      && aw.addr == cache_req.line_addr))
        else value_error("wrong AW burst fields");

    r_last: assert property (@(posedge clk) disable iff (!rst_n)
        (r_valid && r_ready) |-> r.last == (r_beats == `LINE_WORDS - 1))
        else value_error("read burst length or rlast wrong");

    w_beat: assert property (@(posedge clk) disable iff (!rst_n)
        (w_valid && w_ready) |-> (w.strb == '1 && w.last == (w_beats == `LINE_WORDS - 1)
                                  && w.data == exp_line[w_beats]))
        else value_error("wrong W beat data, strobe or wlast");

    w_after_aw: assert property (@(posedge clk) disable iff (!rst_n) w_valid |-> aw_seen)
        else value_error("W beat before AW transfer");

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar)))
        else value_error("AR changed under back-pressure");

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw)))
        else value_error("AW changed under back-pressure");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (w_valid && !w_ready) |=> (w_valid && $stable(w)))
        else value_error("W changed under back-pressure");

    ack_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
        else value_error("ack rose without req");

    ack_fall: assert property (@(posedge clk) disable iff (!rst_n) (ack && !req) |=> !ack)
        else value_error("ack held after req fell");

    // no new burst may start while the previous request is still acked
    ack_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> !(ar_valid || aw_valid || w_valid || r_ready || b_ready))
        else value_error("bus activity while ack is high");

    initial begin : stimulus
        cache_line_t line_v;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = 1'b0;
        cache_req = '0;
        exp_line  = '0;
        lfsr      = SEED;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            shadow[i] = MEM_FILL ^ 32'(i);
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        run_request(OP_REFILL, 32'h40, '0);
        make_line(line_v);
        run_request(OP_WRITEBACK, 32'h80, line_v);
        run_request(OP_REFILL, 32'h80, '0);
        run_request(OP_REFILL, 32'hc0, '0);
        for (int n = 0; n < 6; n++) begin
            make_line(line_v);
            run_request(OP_WRITEBACK, 32'h100 + 32'(n * 16), line_v);
            run_request(OP_REFILL, 32'h100 + 32'(n * 16), '0);
        end
        run_request(OP_REFILL, 32'h40, '0);
        repeat (4) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
logic/axi_pkg.sv
logic/cache_pkg.sv
logic/cache_req_port.sv
logic/line_refill_engine.sv
logic/line_writeback_engine.sv
logic/cache_axi_bridge.sv
sim/tb_axi_mem.sv
sim/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the bridge testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f verilog.f --top-module tb_top -o tb_top_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_top_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Result: PASSED" sim.log; then
    exit 0
fi
exit 1
